//--- spi_pkg.sv
/*
 * SPI master shared definitions
 * Register word layouts, the control register decode, the configuration
 * bundle handed to the datapath and the register map
 */
package spi_pkg;

    // Every register and every transmit or receive word is one 32-bit word
    typedef logic [31:0] spi_word_t;

    typedef logic [3:0] spi_address_t;

    // Control register layout with the start bit in bit 0
    // ss_polarity set means the select line is active high, clear means active low
    // latching_edge clear samples on the leading SCLK edge, set on the trailing one
    // Half an SCLK period lasts divider+1 clock cycles
    // A transfer moves length+1 bits
    typedef struct packed {
        logic [17:0] spare;
        logic [4:0]  length;
        logic [2:0]  divider;
        logic        latching_edge;
        logic        clock_polarity;
        logic        ss_polarity;
        logic        length_select;
        logic        periodic_enable;
        logic        start;
    } spi_ctrl_t;

    // A written word is decoded as control fields at the control address
    // and taken as raw data at every other address
    typedef union packed {
        spi_ctrl_t ctrl;
        spi_word_t raw;
    } spi_write_word_u;

    // Register map, transmit word of channel i lives at spi_addr_tx_base + i
    localparam spi_address_t spi_addr_ctrl    = 4'd0;
    localparam spi_address_t spi_addr_period  = 4'd1;
    localparam spi_address_t spi_addr_tx_base = 4'd2;

    // Stored configuration that steers the datapath
    // The period counts clock cycles between automatic starts
    typedef struct packed {
        spi_word_t  period;
        logic [4:0] length;
        logic [2:0] divider;
        logic       latching_edge;
        logic       clock_polarity;
        logic       ss_polarity;
        logic       length_select;
        logic       periodic_enable;
    } spi_config_t;

endpackage

//--- spi_config_regs.sv
/*
 * SPI master register block
 * Decodes plain register writes into the configuration bundle and the
 * per-channel transmit words, and turns the control start bit into a pulse
 */
`timescale 1ns/1ps

module spi_config_regs #(
    parameter int N_CHANNELS = 3
) (
    input  logic                     clock,
    input  logic                     reset,
    input  logic                     reg_write,
    input  spi_pkg::spi_address_t    reg_address,
    input  spi_pkg::spi_write_word_u reg_write_data,
    output spi_pkg::spi_config_t     spi_config,
    output spi_pkg::spi_word_t       tx_words [N_CHANNELS],
    output logic                     start_request
);
    import spi_pkg::*;

    always_ff @(posedge clock) begin
        if (!reset) begin
            spi_config    <= '0;
            start_request <= 1'b0;
            for (int i = 0; i < N_CHANNELS; i++) begin
                tx_words[i] <= '0;
            end
        end else begin
            // The start bit only ever lives for one cycle
            start_request <= 1'b0;
            if (reg_write) begin
                if (reg_address == spi_addr_ctrl) begin
                    spi_config.periodic_enable <= reg_write_data.ctrl.periodic_enable;
                    spi_config.length_select   <= reg_write_data.ctrl.length_select;
                    spi_config.ss_polarity     <= reg_write_data.ctrl.ss_polarity;
                    spi_config.clock_polarity  <= reg_write_data.ctrl.clock_polarity;
                    spi_config.latching_edge   <= reg_write_data.ctrl.latching_edge;
                    spi_config.divider         <= reg_write_data.ctrl.divider;
                    spi_config.length          <= reg_write_data.ctrl.length;
                    start_request              <= reg_write_data.ctrl.start;
                end else if (reg_address == spi_addr_period) begin
                    spi_config.period <= reg_write_data.raw;
                end else begin
                    for (int i = 0; i < N_CHANNELS; i++) begin
                        if (reg_address == spi_address_t'(spi_addr_tx_base + i)) begin
                            tx_words[i] <= reg_write_data.raw;
                        end
                    end
                end
            end
        end
    end

    // Software must never aim a write past the last transmit word
    write_in_map: assert property (
        @(posedge clock) disable iff (!reset)
        reg_write |-> (reg_address < spi_addr_tx_base + N_CHANNELS)
    );

endmodule

//--- spi_clock_gen.sv
/*
 * SPI clock generator
 * Divides the system clock into SCLK and flags the leading and trailing
 * SCLK edges with one-cycle pulses
 */
`timescale 1ns/1ps

module spi_clock_gen (
    input  logic       clock,
    input  logic       reset,
    input  logic       enable,
    input  logic [2:0] divider,
    input  logic       clock_polarity,
    output logic       sclk,
    output logic       leading_edge,
    output logic       trailing_edge
);

    logic [2:0] half_count;
    logic       active_phase;
    logic       half_end;

    // A half period lasts divider+1 cycles
    assign half_end = (half_count == divider);

    always_ff @(posedge clock) begin
        if (!reset) begin
            half_count    <= '0;
            active_phase  <= 1'b0;
            leading_edge  <= 1'b0;
            trailing_edge <= 1'b0;
        end else if (!enable) begin
            // Park at the idle level so the next transfer starts with a full half period
            half_count    <= '0;
            active_phase  <= 1'b0;
            leading_edge  <= 1'b0;
            trailing_edge <= 1'b0;
        end else begin
            leading_edge  <= half_end && !active_phase;
            trailing_edge <= half_end && active_phase;
            if (half_end) begin
                half_count   <= '0;
                active_phase <= !active_phase;
            end else begin
                half_count <= half_count + 3'd1;
            end
        end
    end

    // The edge pulses line up with the cycle in which the new level shows on sclk
    assign sclk = active_phase ^ clock_polarity;

endmodule

//--- spi_shift_register.sv
/*
 * SPI lane shift register
 * Sends one transmit word MSB first on MOSI and collects the MISO bits
 * right-aligned into a receive word
 */
`timescale 1ns/1ps

module spi_shift_register #(
    parameter int OUTPUT_WIDTH = 32
) (
    input  logic               clock,
    input  logic               reset,
    input  logic               load,
    input  spi_pkg::spi_word_t parallel_in,
    input  logic [4:0]         length,
    input  logic               shift,
    input  logic               sample,
    input  logic               miso,
    output logic               mosi,
    output spi_pkg::spi_word_t parallel_out
);
    import spi_pkg::*;

    spi_word_t               tx_shift;
    logic [OUTPUT_WIDTH-1:0] rx_shift;

    // Transmit side
    always_ff @(posedge clock) begin
        if (!reset) begin
            tx_shift <= '0;
        end else if (load) begin
            // Bit number length becomes bit 31, so it goes out first
            tx_shift <= parallel_in << (5'd31 - length);
        end else if (shift) begin
            tx_shift <= {tx_shift[30:0], 1'b0};
        end
    end

    assign mosi = tx_shift[31];

    // Receive side, the first bit received ends up as the highest of the word
    always_ff @(posedge clock) begin
        if (!reset) begin
            rx_shift <= '0;
        end else if (load) begin
            rx_shift <= '0;
        end else if (sample) begin
            rx_shift <= {rx_shift[OUTPUT_WIDTH-2:0], miso};
        end
    end

    assign parallel_out = spi_word_t'(rx_shift);

endmodule

//--- spi_transfer_engine.sv
/*
 * SPI transfer engine
 * Runs each transfer from start to done: slave select, bit counting, shift
 * and sample strobes, the periodic start timer and the data_valid pulse
 */
`timescale 1ns/1ps

module spi_transfer_engine #(
    parameter int N_CHANNELS   = 3,
    parameter int OUTPUT_WIDTH = 32
) (
    input  logic                    clock,
    input  logic                    reset,
    input  spi_pkg::spi_config_t    spi_config,
    input  logic                    start_request,
    input  logic [4:0]              external_transfer_length,
    input  logic                    leading_edge,
    input  logic                    trailing_edge,
    input  spi_pkg::spi_word_t      lane_words [N_CHANNELS],
    output logic                    clock_enable,
    output logic                    load,
    output logic                    shift,
    output logic                    sample,
    output logic [4:0]              transfer_length,
    output logic                    ss,
    output logic                    data_valid,
    output logic [OUTPUT_WIDTH-1:0] data_out [N_CHANNELS]
);
    import spi_pkg::*;

    localparam logic [1:0] st_idle   = 2'd0;
    localparam logic [1:0] st_load   = 2'd1;
    localparam logic [1:0] st_run    = 2'd2;
    localparam logic [1:0] st_finish = 2'd3;

    logic [1:0] state;
    logic       ss_polarity_q;
    logic       latching_edge_q;
    logic [4:0] bit_count;
    spi_word_t  period_count;
    logic       periodic_tick;
    logic       start_now;
    logic       last_bit;

    // Periodic start timer, one tick every period cycles while enabled
    always_ff @(posedge clock) begin
        if (!reset) begin
            period_count  <= '0;
            periodic_tick <= 1'b0;
        end else if (!spi_config.periodic_enable) begin
            period_count  <= '0;
            periodic_tick <= 1'b0;
        end else if (period_count + 32'd1 >= spi_config.period) begin
            period_count  <= '0;
            periodic_tick <= 1'b1;
        end else begin
            period_count  <= period_count + 32'd1;
            periodic_tick <= 1'b0;
        end
    end

    // Starts outside idle are dropped
    assign start_now = (state == st_idle) && (start_request || periodic_tick);
    assign last_bit  = trailing_edge && (bit_count == transfer_length);

    always_ff @(posedge clock) begin
        if (!reset) begin
            state           <= st_idle;
            ss              <= 1'b1;
            ss_polarity_q   <= 1'b0;
            latching_edge_q <= 1'b0;
            transfer_length <= '0;
            bit_count       <= '0;
        end else begin
            case (state)
                st_idle: begin
                    // While idle the select follows the configured inactive level
                    ss <= start_now ? spi_config.ss_polarity : !spi_config.ss_polarity;
                    if (start_now) begin
                        ss_polarity_q   <= spi_config.ss_polarity;
                        latching_edge_q <= spi_config.latching_edge;
                        transfer_length <= spi_config.length_select ?
                                           external_transfer_length : spi_config.length;
                        state           <= st_load;
                    end
                end
                st_load: begin
                    bit_count <= '0;
                    state     <= st_run;
                end
                st_run: begin
                    if (last_bit) begin
                        ss    <= !ss_polarity_q;
                        state <= st_finish;
                    end else if (trailing_edge) begin
                        bit_count <= bit_count + 5'd1;
                    end
                end
                default: begin
                    state <= st_idle;
                end
            endcase
        end
    end

    // SCLK stops on the final trailing edge so no stray leading edge follows it
    assign clock_enable = (state == st_run) && !last_bit;
    assign load         = (state == st_load);

    // In trailing-edge mode the first bit is already on MOSI, so the first
    // leading edge must not shift
    assign shift  = (state == st_run) &&
                    (latching_edge_q ? (leading_edge && (bit_count != 5'd0)) : trailing_edge);
    assign sample = (state == st_run) && (latching_edge_q ? trailing_edge : leading_edge);

    assign data_valid = (state == st_finish);

    for (genvar i = 0; i < N_CHANNELS; i++) begin : g_data_out
        assign data_out[i] = lane_words[i][OUTPUT_WIDTH-1:0];
    end

    valid_single_cycle: assert property (
        @(posedge clock) disable iff (!reset)
        data_valid |=> !data_valid
    );

    ss_stable_in_run: assert property (
        @(posedge clock) disable iff (!reset)
        (state == st_run) |-> $stable(ss)
    );

endmodule

//--- spi_master.sv
/*
 * Multi-channel SPI master
 * N_CHANNELS MOSI/MISO lane pairs share one SCLK and one slave select
 */
`timescale 1ns/1ps

module spi_master #(
    parameter int N_CHANNELS   = 3,
    parameter int OUTPUT_WIDTH = 32
) (
    input  logic                     clock,
    input  logic                     reset,
    input  logic                     reg_write,
    input  spi_pkg::spi_address_t    reg_address,
    input  spi_pkg::spi_write_word_u reg_write_data,
    input  logic [4:0]               external_transfer_length,
    input  logic                     miso [N_CHANNELS],
    output logic                     mosi [N_CHANNELS],
    output logic                     sclk,
    output logic                     ss,
    output logic                     data_valid,
    output logic [OUTPUT_WIDTH-1:0]  data_out [N_CHANNELS]
);
    import spi_pkg::*;

    spi_config_t spi_config;
    spi_word_t   tx_words [N_CHANNELS];
    spi_word_t   lane_words [N_CHANNELS];
    logic        start_request;
    logic        clock_enable;
    logic        leading_edge;
    logic        trailing_edge;
    logic        load;
    logic        shift;
    logic        sample;
    logic [4:0]  transfer_length;

    spi_config_regs #(
        .N_CHANNELS(N_CHANNELS)
    ) config_regs (
        .clock         (clock),
        .reset         (reset),
        .reg_write     (reg_write),
        .reg_address   (reg_address),
        .reg_write_data(reg_write_data),
        .spi_config    (spi_config),
        .tx_words      (tx_words),
        .start_request (start_request)
    );

    // SCLK idles at the configured polarity between transfers
    spi_clock_gen clock_gen (
        .clock         (clock),
        .reset         (reset),
        .enable        (clock_enable),
        .divider       (spi_config.divider),
        .clock_polarity(spi_config.clock_polarity),
        .sclk          (sclk),
        .leading_edge  (leading_edge),
        .trailing_edge (trailing_edge)
    );

    spi_transfer_engine #(
        .N_CHANNELS  (N_CHANNELS),
        .OUTPUT_WIDTH(OUTPUT_WIDTH)
    ) engine (
        .clock                   (clock),
        .reset                   (reset),
        .spi_config              (spi_config),
        .start_request           (start_request),
        .external_transfer_length(external_transfer_length),
        .leading_edge            (leading_edge),
        .trailing_edge           (trailing_edge),
        .lane_words              (lane_words),
        .clock_enable            (clock_enable),
        .load                    (load),
        .shift                   (shift),
        .sample                  (sample),
        .transfer_length         (transfer_length),
        .ss                      (ss),
        .data_valid              (data_valid),
        .data_out                (data_out)
    );

    // All lanes move in lockstep on the shared strobes
    for (genvar i = 0; i < N_CHANNELS; i++) begin : g_lanes
        spi_shift_register #(
            .OUTPUT_WIDTH(OUTPUT_WIDTH)
        ) lane (
            .clock       (clock),
            .reset       (reset),
            .load        (load),
            .parallel_in (tx_words[i]),
            .length      (transfer_length),
            .shift       (shift),
            .sample      (sample),
            .miso        (miso[i]),
            .mosi        (mosi[i]),
            .parallel_out(lane_words[i])
        );
    end

endmodule

//--- spi_master_tb.sv
/*
 * Testbench for the multi-channel SPI master
 * Runs random register-started and periodic transfers against a slave model
 * per lane and checks received words, sent words and idle levels
 */
`timescale 1ns/1ps

module spi_master_tb;
    import spi_pkg::*;

    localparam int n_channels     = 3;
    localparam int output_width   = 32;
    // Slowest transfer is 2*8 cycles per bit for 32 bits, plus start and finish
    localparam int timeout_cycles = 2 * 8 * 33 + 64;

    logic                    clock = 1'b0;
    logic                    reset;
    logic                    reg_write;
    spi_address_t            reg_address;
    spi_write_word_u         reg_write_data;
    logic [4:0]              external_transfer_length;
    logic                    miso [n_channels];
    logic                    mosi [n_channels];
    logic                    sclk;
    logic                    ss;
    logic                    data_valid;
    logic [output_width-1:0] data_out [n_channels];

    // Current control setting and the slave model state
    spi_ctrl_t ctrl;
    spi_word_t tx_model [n_channels];
    spi_word_t slave_words [n_channels];
    spi_word_t captured [n_channels];
    int        bit_index;
    int        edge_count;
    int        sampled_bits;
    logic      last_sclk;

    spi_master #(
        .N_CHANNELS  (n_channels),
        .OUTPUT_WIDTH(output_width)
    ) dut (
        .clock                   (clock),
        .reset                   (reset),
        .reg_write               (reg_write),
        .reg_address             (reg_address),
        .reg_write_data          (reg_write_data),
        .external_transfer_length(external_transfer_length),
        .miso                    (miso),
        .mosi                    (mosi),
        .sclk                    (sclk),
        .ss                      (ss),
        .data_valid              (data_valid),
        .data_out                (data_out)
    );

    always #5 clock = ~clock;

    task automatic stop_with_failure(string reason);
        $display("%s", reason);
        $display(">>> FAIL");
        $fatal(1, "Simulation stopped at the first failed check");
    endtask

    task automatic check_word(string name, spi_word_t expected, spi_word_t actual);
        if (actual !== expected) begin
            stop_with_failure($sformatf("Mismatch %s: expected %h, actual %h",
                                        name, expected, actual));
        end
    endtask

    task automatic check_level(string name, logic expected, logic actual);
        if (actual !== expected) begin
            stop_with_failure($sformatf("Mismatch %s: expected %b, actual %b",
                                        name, expected, actual));
        end
    endtask

    // Bits length down to 0 set
    function automatic spi_word_t low_mask(int length);
        return spi_word_t'((64'd1 << (length + 1)) - 64'd1);
    endfunction

    // Called on a falling edge, the write lands on the next rising edge
    task automatic write_register(spi_address_t address, spi_word_t value);
        reg_write          = 1'b1;
        reg_address        = address;
        reg_write_data.raw = value;
        @(negedge clock);
        reg_write = 1'b0;
    endtask

    task automatic load_tx_words();
        for (int i = 0; i < n_channels; i++) begin
            tx_model[i] = $urandom();
            write_register(spi_address_t'(spi_addr_tx_base + i), tx_model[i]);
        end
    endtask

    // Fresh slave words, with the first MISO bit ready before the first edge
    task automatic prepare_slaves(int length);
        bit_index    = length;
        edge_count   = 0;
        sampled_bits = 0;
        for (int i = 0; i < n_channels; i++) begin
            slave_words[i] = $urandom();
            captured[i]    = '0;
            miso[i]        = slave_words[i][length];
        end
    endtask

    // Slave side of one falling clock edge, SCLK moved on the rising edge before
    task automatic follow_sclk();
        logic leading;
        if (sclk !== last_sclk) begin
            leading = (sclk != ctrl.clock_polarity);
            check_level("ss active during transfer", ctrl.ss_polarity, ss);
            if (leading ^ ctrl.latching_edge) begin
                for (int i = 0; i < n_channels; i++) begin
                    captured[i] = {captured[i][30:0], mosi[i]};
                end
                sampled_bits++;
            end else if (!(ctrl.latching_edge && edge_count == 0)) begin
                // The first leading edge in trailing-edge mode carries no new bit
                bit_index--;
                for (int i = 0; i < n_channels; i++) begin
                    miso[i] = (bit_index >= 0) ? slave_words[i][bit_index] : 1'b0;
                end
            end
            edge_count++;
            last_sclk = sclk;
        end
    endtask

    task automatic wait_for_done(string name);
        int cycles;
        cycles    = 0;
        last_sclk = ctrl.clock_polarity;
        while (data_valid !== 1'b1) begin
            follow_sclk();
            if (cycles == timeout_cycles) begin
                stop_with_failure($sformatf("Timeout: no data_valid within %0d cycles in %s",
                                            timeout_cycles, name));
            end
            cycles++;
            @(negedge clock);
        end
    endtask

    task automatic check_results(string name, int length);
        spi_word_t mask;
        mask = low_mask(length);
        for (int i = 0; i < n_channels; i++) begin
            check_word($sformatf("%s lane %0d data_out", name, i),
                       slave_words[i] & mask, spi_word_t'(data_out[i]));
            check_word($sformatf("%s lane %0d mosi", name, i), tx_model[i] & mask, captured[i]);
        end
        check_word({name, " bit count"}, spi_word_t'(length + 1), spi_word_t'(sampled_bits));
        check_level({name, " ss idle"}, !ctrl.ss_polarity, ss);
        check_level({name, " sclk idle"}, ctrl.clock_polarity, sclk);
        @(negedge clock);
        check_level({name, " data_valid width"}, 1'b0, data_valid);
    endtask

    task automatic run_register_transfer(string name, logic ss_polarity, logic use_external);
        int length;
        ctrl                     = '0;
        ctrl.divider             = 3'($urandom_range(0, 7));
        ctrl.length              = 5'($urandom_range(0, 31));
        ctrl.clock_polarity      = 1'($urandom_range(0, 1));
        ctrl.latching_edge       = 1'($urandom_range(0, 1));
        ctrl.ss_polarity         = ss_polarity;
        ctrl.length_select       = use_external;
        external_transfer_length = 5'($urandom_range(0, 31));
        // Register length differs from the pin so a wrong choice shows in the bit count
        if (use_external) begin
            ctrl.length = external_transfer_length ^ 5'd1;
        end
        length = use_external ? int'(external_transfer_length) : int'(ctrl.length);
        load_tx_words();
        prepare_slaves(length);
        ctrl.start = 1'b1;
        write_register(spi_addr_ctrl, spi_word_t'(ctrl));
        ctrl.start = 1'b0;
        wait_for_done(name);
        check_results(name, length);
    endtask

    task automatic run_periodic(string name);
        int        length;
        spi_word_t period;
        string     pulse_name;
        ctrl                = '0;
        ctrl.divider        = 3'($urandom_range(0, 3));
        ctrl.length         = 5'($urandom_range(0, 15));
        ctrl.clock_polarity = 1'($urandom_range(0, 1));
        ctrl.latching_edge  = 1'($urandom_range(0, 1));
        ctrl.ss_polarity    = 1'($urandom_range(0, 1));
        length              = int'(ctrl.length);
        // Longer than a whole transfer, so every tick finds the engine idle
        period = spi_word_t'(2 * (ctrl.divider + 1) * (length + 1) + 8 + $urandom_range(0, 100));
        load_tx_words();
        write_register(spi_addr_period, period);
        prepare_slaves(length);
        ctrl.periodic_enable = 1'b1;
        write_register(spi_addr_ctrl, spi_word_t'(ctrl));
        for (int p = 0; p < 4; p++) begin
            pulse_name = $sformatf("%s pulse %0d", name, p);
            wait_for_done(pulse_name);
            check_results(pulse_name, length);
            prepare_slaves(length);
        end
        ctrl.periodic_enable = 1'b0;
        write_register(spi_addr_ctrl, spi_word_t'(ctrl));
        repeat (timeout_cycles) begin
            check_level({name, " no pulse after stop"}, 1'b0, data_valid);
            @(negedge clock);
        end
    endtask

    initial begin
        void'($urandom(52480));
        reset                    = 1'b0;
        reg_write                = 1'b0;
        reg_address              = '0;
        reg_write_data           = '0;
        external_transfer_length = '0;
        ctrl                     = '0;
        for (int i = 0; i < n_channels; i++) begin
            miso[i] = 1'b0;
        end
        repeat (16) @(negedge clock);
        reset = 1'b1;

        // Select polarity resets to active low, so the select idles high
        check_level("reset ss", 1'b1, ss);
        check_level("reset sclk", 1'b0, sclk);
        repeat (20) begin
            @(negedge clock);
            check_level("reset data_valid", 1'b0, data_valid);
        end

        // Second half runs with an active-high select, every third uses the length pin
        for (int t = 0; t < 24; t++) begin
            run_register_transfer($sformatf("transfer %0d", t), 1'(t / 12), (t % 3) == 2);
        end
        run_periodic("periodic");

        $display(">>> PASS");
        $finish;
    end

endmodule

//--- spi_master.f
spi_pkg.sv
spi_config_regs.sv
spi_clock_gen.sv
spi_shift_register.sv
spi_transfer_engine.sv
spi_master.sv
spi_master_tb.sv

//--- Makefile
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert -Wno-fatal
TOP       := spi_master_tb
FILELIST  := spi_master.f

SOURCES   := $(shell cat $(FILELIST))
BINARY    := obj_dir/V$(TOP)

.PHONY: all run clean

all: run

$(BINARY): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

# The run passes only when the pass line shows up in the output
run: $(BINARY)
	./$(BINARY) | awk '{ print } /^>>> PASS$$/ { ok = 1 } END { exit !ok }'

clean:
	rm -rf obj_dir
